//--- project.f
src/spi_emu_pkg.sv
src/spi_shifter.sv
src/read_sequencer.sv
src/image_memory.sv
src/txn_logger.sv
src/spi_emu_top.sv
tb/spi_emu_checker.sv
tb/spi_emu_tb.sv

//--- Makefile
# Verilator build and run for the SPI flash emulator

VERILATOR ?= verilator
TOP       ?= spi_emu_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_MSG  ?= Test passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$($(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- tb/spi_emu_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for spi_emu_top with an SPI mode 0 host at 8 clk per half period
// image is loaded with random bytes and byte 0 forced to zero
// the run stops at the first mismatch
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module spi_emu_tb;

	localparam int clk_period = 40;
	localparam int spi_half   = 8;
	localparam int num_rows   = 8;

	// one SPI transaction and what the logger should make of it
	typedef struct {
		string                          name;
		logic [7:0]                     opcode;
		logic [23:0]                    addr;
		int                             count;
		bit                             inj;
		logic [spi_emu_pkg::mem_aw-1:0] inj_addr;
		int                             stall;
	} row_t;

	logic                  clk;
	logic                  rst_n;
	logic                  spi_clk;
	logic                  spi_cs_n;
	logic                  spi_mosi;
	logic                  spi_miso;
	spi_emu_pkg::host_wr_t host_wr;
	logic                  host_busy;
	logic [7:0]            log_data;
	logic                  log_valid;
	logic                  log_ready;

	// reference copy of the image
	logic [7:0] model [spi_emu_pkg::mem_depth];
	logic [7:0] log_got [$];
	row_t       rows [num_rows];

	spi_emu_top u_spi_emu_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.spi_clk   (spi_clk),
		.spi_cs_n  (spi_cs_n),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso),
		.host_wr   (host_wr),
		.host_busy (host_busy),
		.log_data  (log_data),
		.log_valid (log_valid),
		.log_ready (log_ready)
	);

	bind spi_emu_top spi_emu_checker u_checker (
		.clk       (clk),
		.rst_n     (rst_n),
		.spi_cs_n  (spi_cs_n),
		.spi_miso  (spi_miso),
		.host_busy (host_busy),
		.log_data  (log_data),
		.log_valid (log_valid),
		.log_ready (log_ready)
	);

	always #(clk_period / 2) clk = ~clk;

	// log monitor takes one byte per accepted handshake at mid-cycle
	always @(negedge clk) begin
		if (rst_n && log_valid && log_ready)
			log_got.push_back(log_data);
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			fail_run($sformatf("ERR %s expected %0h actual %0h", name, exp, act));
	endtask

	task automatic watchdog(input longint limit_ns);
		#(limit_ns);
		fail_run($sformatf("timeout, the tests did not finish within %0d ns", limit_ns));
	endtask

	// advance n clocks and land 2 ns past the edge
	task automatic cycles(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	// one byte MSB first with miso sampled just before each rising edge
	task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
		for (int i = 7; i >= 0; i--) begin
			spi_mosi = tx[i];
			cycles(spi_half);
			rx[i] = spi_miso;
			spi_clk = 1'b1;
			cycles(spi_half);
			spi_clk = 1'b0;
		end
	endtask

	task automatic set_row(input int idx, input string name, input logic [7:0] opcode,
		input logic [23:0] addr, input int count, input bit inj,
		input logic [spi_emu_pkg::mem_aw-1:0] inj_addr, input int stall);
		rows[idx].name     = name;
		rows[idx].opcode   = opcode;
		rows[idx].addr     = addr;
		rows[idx].count    = count;
		rows[idx].inj      = inj;
		rows[idx].inj_addr = inj_addr;
		rows[idx].stall    = stall;
	endtask

	task automatic build_table();
		set_row(0, "read_basic", 8'h03, 24'h000120, 4, 1'b0, '0, 0);
		// low bits 0x3FE so the read runs over the end of the image
		set_row(1, "read_wrap", 8'h03, 24'h1237FE, 5, 1'b0, '0, 0);
		set_row(2, "non_read", 8'h0B, 24'h000040, 3, 1'b0, '0, 0);
		set_row(3, "zero_entry", 8'h03, 24'h000000, 2, 1'b0, '0, 0);
		set_row(4, "busy_write", 8'h03, 24'h000200, 4, 1'b1, 10'h202, 0);
		set_row(5, "busy_readback", 8'h03, 24'h000202, 2, 1'b0, '0, 0);
		set_row(6, "log_stall", 8'h03, 24'hABC155, 3, 1'b0, '0, 25);
		set_row(7, "no_data", 8'h03, 24'h000300, 0, 1'b0, '0, 0);
	endtask

	task automatic run_row(input row_t r);
		logic [7:0] hdr [4];
		logic [7:0] rx;
		logic [7:0] exp;
		logic [7:0] first;
		logic [7:0] inj_data;
		bit         is_read;
		bit         log_exp;
		int         idx;
		int         waited;

		hdr[0] = r.opcode;
		hdr[1] = r.addr[23:16];
		hdr[2] = r.addr[15:8];
		hdr[3] = r.addr[7:0];
		is_read = (r.opcode == spi_emu_pkg::op_read);
		first = model[int'(r.addr) % spi_emu_pkg::mem_depth];
		// an all-zero entry is never sent
		log_exp = is_read && (r.count > 0) && ({r.addr, first} != 32'h0);
		inj_data = model[r.inj_addr] ^ 8'hFF;
		log_got.delete();
		log_ready = (r.stall == 0);
		spi_cs_n = 1'b0;
		cycles(spi_half);
		// the target only drives idle bytes during command and address
		for (int j = 0; j < 4; j++) begin
			spi_byte(hdr[j], rx);
			check($sformatf("%s cmd byte %0d", r.name, j), spi_emu_pkg::idle_byte, rx);
		end
		if (r.inj) begin
			check({r.name, " host_busy"}, 1, host_busy);
			host_wr = '{addr: r.inj_addr, data: inj_data, strobe: 1'b1};
			cycles(1);
			host_wr = '0;
		end
		for (int j = 0; j < r.count; j++) begin
			idx = (int'(r.addr) + j) % spi_emu_pkg::mem_depth;
			exp = is_read ? model[idx] : spi_emu_pkg::idle_byte;
			spi_byte(8'h00, rx);
			check($sformatf("%s data byte %0d", r.name, j), exp, rx);
		end
		cycles(spi_half);
		spi_cs_n = 1'b1;
		spi_mosi = 1'b0;
		// buffered write lands once the read lets go of the memory
		if (r.inj)
			model[r.inj_addr] = inj_data;
		if (r.stall > 0) begin
			cycles(r.stall);
			check({r.name, " valid while stalled"}, log_exp, log_valid);
			// the address high byte waits at the head of the stream
			if (log_exp)
				check({r.name, " data while stalled"}, r.addr[23:16], log_data);
			log_ready = 1'b1;
		end
		if (log_exp) begin
			waited = 0;
			while (log_got.size() < 4 && waited < 40) begin
				cycles(1);
				waited++;
			end
			if (log_got.size() < 4)
				fail_run($sformatf("%s: log stream stopped after %0d of 4 bytes",
					r.name, log_got.size()));
			cycles(4);
			check({r.name, " log count"}, 4, log_got.size());
			check({r.name, " log addr high"}, r.addr[23:16], log_got[0]);
			check({r.name, " log addr mid"}, r.addr[15:8], log_got[1]);
			check({r.name, " log addr low"}, r.addr[7:0], log_got[2]);
			check({r.name, " log data"}, first, log_got[3]);
		end else begin
			cycles(16);
			check({r.name, " log count"}, 0, log_got.size());
		end
		check({r.name, " host_busy after deselect"}, 0, host_busy);
		cycles(2 * spi_half);
	endtask

	initial begin
		longint     limit;
		logic [7:0] b;

		clk = 1'b0;
		rst_n = 1'b0;
		spi_clk = 1'b0;
		spi_cs_n = 1'b1;
		spi_mosi = 1'b0;
		host_wr = '0;
		log_ready = 1'b1;
		void'($urandom(32'h2c0eb30f));
		build_table();
		// bit time of every byte over all rows plus image load and per row slack
		limit = 0;
		foreach (rows[i])
			limit += longint'(4 + rows[i].count) * 8 * 2 * spi_half * clk_period;
		limit += longint'(spi_emu_pkg::mem_depth + 200 * num_rows) * clk_period;
		fork
			watchdog(limit);
		join_none
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		cycles(2);
		// image load with one write per cycle
		for (int a = 0; a < spi_emu_pkg::mem_depth; a++) begin
			b = (a == 0) ? 8'h00 : 8'($urandom);
			model[a] = b;
			host_wr = '{addr: a[spi_emu_pkg::mem_aw-1:0], data: b, strobe: 1'b1};
			cycles(1);
		end
		host_wr = '0;
		cycles(4);
		foreach (rows[i])
			run_row(rows[i]);
		$display("Test passed");
		$finish;
	end

endmodule

//--- tb/spi_emu_checker.sv
////////////////////////////////////////////////////////////////////////////
// protocol assertions bound into spi_emu_top
// all properties are off while rst_n is low
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module spi_emu_checker (
	input logic       clk,
	input logic       rst_n,
	input logic       spi_cs_n,
	input logic       spi_miso,
	input logic       host_busy,
	input logic [7:0] log_data,
	input logic       log_valid,
	input logic       log_ready
);

	// a stalled log byte keeps valid and data until it is taken
	log_hold: assert property (@(posedge clk) disable iff (!rst_n)
		log_valid && !log_ready |=> log_valid && $stable(log_data))
		else $error("log byte changed under back-pressure");

	// deselect reaches the sequencer through the synchronizer, busy drops soon after
	busy_release: assert property (@(posedge clk) disable iff (!rst_n)
		spi_cs_n && $past(spi_cs_n) && $past(spi_cs_n, 2) && $past(spi_cs_n, 3)
		|=> !host_busy)
		else $error("host_busy still high with chip select released");

	// miso is always a driven level while selected
	miso_known: assert property (@(posedge clk) disable iff (!rst_n)
		!spi_cs_n |-> !$isunknown(spi_miso))
		else $error("spi_miso unknown during a transaction");

endmodule

//--- src/spi_emu_top.sv
////////////////////////////////////////////////////////////////////////////
// SPI flash emulator top, single clock domain clk
// SPI pins are asynchronous and synchronized inside the shifter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module spi_emu_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  spi_clk,
	input  logic                  spi_cs_n,
	input  logic                  spi_mosi,
	output logic                  spi_miso,
	input  spi_emu_pkg::host_wr_t host_wr,
	output logic                  host_busy,
	output logic [7:0]            log_data,
	output logic                  log_valid,
	input  logic                  log_ready
);

	logic [7:0]              rx_data;
	logic                    rx_strobe;
	logic                    cs_rise;
	logic [7:0]              tx_data;
	logic                    tx_load;
	spi_emu_pkg::mem_rd_t    mem_rd;
	logic [7:0]              rd_data;
	logic                    critical;
	logic                    log_capture;
	spi_emu_pkg::log_entry_t log_entry;

	spi_shifter u_shifter (
		.clk       (clk),
		.rst_n     (rst_n),
		.spi_clk   (spi_clk),
		.spi_cs_n  (spi_cs_n),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso),
		.rx_data   (rx_data),
		.rx_strobe (rx_strobe),
		.cs_rise   (cs_rise),
		.tx_data   (tx_data),
		.tx_load   (tx_load)
	);

	read_sequencer u_seq (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_data     (rx_data),
		.rx_strobe   (rx_strobe),
		.cs_rise     (cs_rise),
		.tx_data     (tx_data),
		.tx_load     (tx_load),
		.mem_rd      (mem_rd),
		.rd_data     (rd_data),
		.critical    (critical),
		.log_capture (log_capture),
		.log_entry   (log_entry)
	);

	image_memory u_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.host_wr   (host_wr),
		.host_busy (host_busy),
		.mem_rd    (mem_rd),
		.critical  (critical),
		.rd_data   (rd_data)
	);

	txn_logger u_logger (
		.clk         (clk),
		.rst_n       (rst_n),
		.log_capture (log_capture),
		.log_entry   (log_entry),
		.log_data    (log_data),
		.log_valid   (log_valid),
		.log_ready   (log_ready)
	);

endmodule

//--- src/txn_logger.sv
////////////////////////////////////////////////////////////////////////////
// read transaction logger, four bytes per entry on a valid/ready stream
// holds one entry only, captures arriving while busy are lost
// all-zero entries are never sent
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module txn_logger (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    log_capture,
	input  spi_emu_pkg::log_entry_t log_entry,
	output logic [7:0]              log_data,
	output logic                    log_valid,
	input  logic                    log_ready
);

	localparam int log_w = $bits(spi_emu_pkg::log_entry_t);

	// bytes still to send, 0 means idle
	logic [2:0]       cnt;
	logic [log_w-1:0] sh;
	logic             take;
	logic             xfer;

	assign take = log_capture && (cnt == 3'd0) && (log_entry != '0);
	assign xfer = log_valid && log_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (take) begin
			cnt <= 3'd4;
		end else if (xfer) begin
			cnt <= cnt - 3'd1;
		end
	end

	// entry shifts up a byte per transfer, most significant byte first
	always_ff @(posedge clk) begin
		if (take)
			sh <= log_entry;
		else if (xfer)
			sh <= {sh[log_w-9:0], 8'h00};
	end

	// both driven from registers so they hold under back-pressure
	assign log_valid = (cnt != 3'd0);
	assign log_data  = sh[log_w-1 -: 8];

endmodule

//--- src/image_memory.sv
////////////////////////////////////////////////////////////////////////////
// flash image store, one byte wide, registered read
// host writes during a read transaction wait in a single buffer
// a second write while that buffer is full replaces the first
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module image_memory (
	input  logic                  clk,
	input  logic                  rst_n,
	input  spi_emu_pkg::host_wr_t host_wr,
	output logic                  host_busy,
	input  spi_emu_pkg::mem_rd_t  mem_rd,
	input  logic                  critical,
	output logic [7:0]            rd_data
);

	logic [7:0] mem [spi_emu_pkg::mem_depth];

	// buffered host write, drains once the read transaction is over
	spi_emu_pkg::host_wr_t pend;
	spi_emu_pkg::host_wr_t wr_sel;
	logic                  wr_en;

	// sequencer owns the memory while critical
	assign host_busy = critical;

	// older buffered write goes first
	assign wr_sel = pend.strobe ? pend : host_wr;
	assign wr_en  = !critical && wr_sel.strobe;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pend <= '0;
		end else if (critical) begin
			if (host_wr.strobe)
				pend <= host_wr;
		end else if (pend.strobe) begin
			// buffer drains now, keep any write arriving on the same cycle
			pend <= host_wr;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_sel.addr] <= wr_sel.data;
		if (mem_rd.strobe)
			rd_data <= mem[mem_rd.addr];
	end

endmodule

//--- src/read_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// read command decoder and memory fetch sequencer
// only op_read touches memory, other opcodes answer with idle bytes
// memory data is passed straight to tx_data on its return cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module read_sequencer (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [7:0]              rx_data,
	input  logic                    rx_strobe,
	input  logic                    cs_rise,
	output logic [7:0]              tx_data,
	output logic                    tx_load,
	output spi_emu_pkg::mem_rd_t    mem_rd,
	input  logic [7:0]              rd_data,
	output logic                    critical,
	output logic                    log_capture,
	output spi_emu_pkg::log_entry_t log_entry
);

	spi_emu_pkg::seq_state_e state;
	spi_emu_pkg::opcode_e    opcode_q;

	logic [1:0]                     addr_cnt;
	logic [spi_emu_pkg::addr_w-1:0] addr_q;
	logic [spi_emu_pkg::addr_w-1:0] addr_next;
	logic [spi_emu_pkg::mem_aw-1:0] rd_ptr;
	// read return and idle load pipelines
	logic                           rd_valid;
	logic                           idle_ld;
	logic                           idle_ld_q;
	// at least one data byte fully clocked out
	logic                           sent;
	logic                           first_done;
	logic [7:0]                     first_byte;

	// address including the byte just received
	assign addr_next = {addr_q[spi_emu_pkg::addr_w-9:0], rx_data};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= spi_emu_pkg::st_idle;
			opcode_q    <= spi_emu_pkg::op_read;
			addr_cnt    <= '0;
			addr_q      <= '0;
			rd_ptr      <= '0;
			mem_rd      <= '0;
			rd_valid    <= 1'b0;
			idle_ld     <= 1'b0;
			idle_ld_q   <= 1'b0;
			critical    <= 1'b0;
			log_capture <= 1'b0;
			sent        <= 1'b0;
			first_done  <= 1'b0;
			first_byte  <= '0;
		end else begin
			mem_rd.strobe <= 1'b0;
			log_capture   <= 1'b0;
			idle_ld       <= 1'b0;
			rd_valid      <= mem_rd.strobe;
			idle_ld_q     <= idle_ld;
			if (cs_rise) begin
				// end of transaction, release memory and log completed reads
				state    <= spi_emu_pkg::st_idle;
				critical <= 1'b0;
				if (state == spi_emu_pkg::st_data && sent)
					log_capture <= 1'b1;
			end else begin
				case (state)
					spi_emu_pkg::st_idle: begin
						if (rx_strobe) begin
							opcode_q <= spi_emu_pkg::opcode_e'(rx_data);
							state    <= spi_emu_pkg::st_opcode;
						end
					end
					spi_emu_pkg::st_opcode: begin
						if (opcode_q == spi_emu_pkg::op_read) begin
							critical <= 1'b1;
							addr_cnt <= '0;
							state    <= spi_emu_pkg::st_addr;
						end else begin
							state <= spi_emu_pkg::st_ignore;
						end
					end
					spi_emu_pkg::st_addr: begin
						if (rx_strobe) begin
							addr_q   <= addr_next;
							addr_cnt <= addr_cnt + 2'd1;
							if (addr_cnt == 2'd2) begin
								// third address byte, fetch the first data byte
								mem_rd.strobe <= 1'b1;
								mem_rd.addr   <= addr_next[spi_emu_pkg::mem_aw-1:0];
								rd_ptr        <= addr_next[spi_emu_pkg::mem_aw-1:0] + 1'b1;
								sent          <= 1'b0;
								first_done    <= 1'b0;
								state         <= spi_emu_pkg::st_data;
							end
						end
					end
					spi_emu_pkg::st_data: begin
						if (rd_valid && !first_done) begin
							first_byte <= rd_data;
							first_done <= 1'b1;
						end
						if (rx_strobe) begin
							// prefetch next byte, pointer wraps at memory depth
							sent          <= 1'b1;
							mem_rd.strobe <= 1'b1;
							mem_rd.addr   <= rd_ptr;
							rd_ptr        <= rd_ptr + 1'b1;
						end
					end
					spi_emu_pkg::st_ignore: begin
						if (rx_strobe)
							idle_ld <= 1'b1;
					end
					default: state <= spi_emu_pkg::st_idle;
				endcase
			end
		end
	end

	assign tx_load   = rd_valid | idle_ld_q;
	assign tx_data   = rd_valid ? rd_data : spi_emu_pkg::idle_byte;
	assign log_entry = '{addr: addr_q, data: first_byte};

endmodule

//--- src/spi_shifter.sv
////////////////////////////////////////////////////////////////////////////
// SPI mode 0 target shifter running entirely on clk
// spi_clk must stay at least 6 clk cycles per half period
// tx_load puts the MSB out at once, the next falling edge is skipped
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module spi_shifter (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       spi_clk,
	input  logic       spi_cs_n,
	input  logic       spi_mosi,
	output logic       spi_miso,
	output logic [7:0] rx_data,
	output logic       rx_strobe,
	output logic       cs_rise,
	input  logic [7:0] tx_data,
	input  logic       tx_load
);

	// two synchronizer flops plus one history flop for edge detection
	logic [2:0] clk_sync;
	logic [2:0] cs_sync;
	logic [1:0] mosi_sync;

	logic       clk_rise;
	logic       clk_fall;
	logic       cs_high;

	logic [2:0] bit_cnt;
	logic [6:0] rx_shift;
	logic [7:0] tx_shift;
	// set by a load so the following falling edge keeps the MSB
	logic       skip_fall;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync  <= '0;
			cs_sync   <= '1;
			mosi_sync <= '0;
		end else begin
			clk_sync  <= {clk_sync[1:0], spi_clk};
			cs_sync   <= {cs_sync[1:0], spi_cs_n};
			mosi_sync <= {mosi_sync[0], spi_mosi};
		end
	end

	assign clk_rise = clk_sync[1] & ~clk_sync[2];
	assign clk_fall = ~clk_sync[1] & clk_sync[2];
	assign cs_high  = cs_sync[1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt   <= '0;
			rx_strobe <= 1'b0;
			cs_rise   <= 1'b0;
			tx_shift  <= '1;
			skip_fall <= 1'b0;
		end else begin
			rx_strobe <= 1'b0;
			cs_rise   <= cs_sync[1] & ~cs_sync[2];
			if (cs_high) begin
				// deselected, restart byte framing and idle the line high
				bit_cnt   <= '0;
				tx_shift  <= '1;
				skip_fall <= 1'b0;
			end else begin
				if (clk_rise) begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
						rx_strobe <= 1'b1;
				end
				if (tx_load) begin
					tx_shift  <= tx_data;
					skip_fall <= 1'b1;
				end else if (clk_fall) begin
					if (skip_fall)
						skip_fall <= 1'b0;
					else
						tx_shift <= {tx_shift[6:0], 1'b1};
				end
			end
		end
	end

	// receive data path, MSB first
	always_ff @(posedge clk) begin
		if (!cs_high && clk_rise) begin
			rx_shift <= {rx_shift[5:0], mosi_sync[1]};
			if (bit_cnt == 3'd7)
				rx_data <= {rx_shift, mosi_sync[1]};
		end
	end

	assign spi_miso = tx_shift[7];

endmodule

//--- src/spi_emu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared widths, enums and bundles for the SPI flash emulator
// only the low mem_aw bits of the 24-bit SPI address reach the memory,
// so the 1 KB image repeats across the whole address space
////////////////////////////////////////////////////////////////////////////

package spi_emu_pkg;

	// SPI address width, one 24-bit word
	localparam int addr_w = 24;
	// image memory address width, 1 KB
	localparam int mem_aw = 10;
	localparam int mem_depth = 1 << mem_aw;

	// byte driven when no memory data is available
	localparam logic [7:0] idle_byte = 8'hFF;

	// only plain read is served, everything else reads as idle bytes
	typedef enum logic [7:0] {
		op_read = 8'h03
	} opcode_e;

	typedef enum logic [2:0] {
		st_idle,
		st_opcode,
		st_addr,
		st_data,
		st_ignore
	} seq_state_e;

	// host image load port
	typedef struct packed {
		logic [mem_aw-1:0] addr;
		logic [7:0]        data;
		logic              strobe;
	} host_wr_t;

	// sequencer read request, data returns one cycle later
	typedef struct packed {
		logic [mem_aw-1:0] addr;
		logic              strobe;
	} mem_rd_t;

	// one logged read, address bytes first, 32 bits total
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [7:0]        data;
	} log_entry_t;

endpackage
